//--- Bender.yml
package:
  name: vic_board

sources:
  - rtl/vic_pkg.sv
  - rtl/clk_div4.sv
  - rtl/phi_gen.sv
  - rtl/raster_timing.sv
  - rtl/vic_regs.sv
  - rtl/color_out.sv
  - rtl/vicii.sv
  - rtl/vic_board.sv
  - target: test
    files:
      - tests/tb_vic_board.sv

//--- rtl/clk_div4.sv
module clk_div4 (
  input  logic clk_col4x,   // 4x colour clock
  input  logic rst,
  output logic clk_colref   // colour reference out
);

  logic [1:0] cnt;  // free running divider

  always_ff @(posedge clk_col4x) begin
    if (rst) begin
      cnt <= 2'd0;
    end else begin
      cnt <= cnt + 2'd1;
    end
  end

  assign clk_colref = cnt[1];  // high for 2 of every 4 input cycles

  // output may only move when the low bit carries into the top bit
  a_colref_on_carry : assert property (
    @(posedge clk_col4x) disable iff (rst)
    $changed(clk_colref) |-> $past(cnt[0])
  ) else $error("clk_colref changed without a carry");

endmodule : clk_div4

//--- rtl/color_out.sv
module color_out
  import vic_pkg::*;
#(
  parameter int LINES  = 312,
  parameter int CYCLES = 63
) (
  input  logic   clk_dot4x,
  input  logic   rst,
  input  xpos_t  raster_x,
  input  ypos_t  raster_y,
  input  color_t border_color,
  input  color_t bg_color,
  output rgb_t   rgb
);

  localparam xpos_t LINE_PX  = xpos_t'(8 * CYCLES);
  localparam xpos_t WIN_X_END = LINE_PX - HBORDER_PX;            // right border start
  localparam ypos_t WIN_Y_END = ypos_t'(LINES) - VBORDER_LINES;  // bottom border start

  logic blank_q;   // stage 1 blank flag
  logic window_q;  // stage 1 display window flag

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      blank_q  <= 1'b1;
      window_q <= 1'b0;
      rgb      <= '0;
    end else begin
      blank_q  <= (raster_x < HBLANK_PX) || (raster_y < VBLANK_LINES);
      window_q <= (raster_x >= HBORDER_PX) && (raster_x < WIN_X_END) &&
                  (raster_y >= VBORDER_LINES) && (raster_y < WIN_Y_END);
      if (blank_q) begin
        rgb <= '0;                       // black during blank
      end else if (window_q) begin
        rgb <= PALETTE[bg_color];
      end else begin
        rgb <= PALETTE[border_color];
      end
    end
  end

endmodule : color_out

//--- rtl/phi_gen.sv
module phi_gen (
  input  logic clk_dot4x,
  input  logic rst,
  output logic dot_tick,  // one per pixel
  output logic clk_phi,   // cpu phase clock
  output logic phi_end    // last cycle of phi high
);

  logic [4:0] phase;  // 32 cycles per phi period, 8 dots

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      phase <= 5'd0;
    end else begin
      phase <= phase + 5'd1;  // wraps at 31
    end
  end

  assign dot_tick = (phase[1:0] == 2'd3);  // last quarter of each dot
  assign clk_phi  = phase[4];              // low 16, high 16
  assign phi_end  = (phase == 5'd31);

  // bus writes land on phi_end and must coincide with a pixel step
  a_end_on_tick : assert property (
    @(posedge clk_dot4x) disable iff (rst)
    phi_end |-> dot_tick
  ) else $error("phi_end without dot_tick");

endmodule : phi_gen

//--- rtl/raster_timing.sv
module raster_timing
  import vic_pkg::*;
#(
  parameter int LINES  = 312,  // lines per frame
  parameter int CYCLES = 63    // phi cycles per line
) (
  input  logic  clk_dot4x,
  input  logic  rst,
  input  logic  dot_tick,    // pixel step
  output xpos_t raster_x,
  output ypos_t raster_y,
  output logic  line_start,  // first cycle of a new line
  output logic  csync        // composite sync, active low
);

  localparam xpos_t LINE_PX  = xpos_t'(8 * CYCLES);  // 8 dots per phi
  localparam xpos_t LAST_X   = LINE_PX - 10'd1;
  localparam ypos_t LAST_Y   = ypos_t'(LINES - 1);

  logic x_wrap;  // last pixel of the line
  logic sync_q;  // first sync stage

  assign x_wrap = (raster_x == LAST_X);

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      raster_x   <= '0;
      raster_y   <= '0;
      line_start <= 1'b0;
    end else begin
      line_start <= dot_tick && x_wrap;  // high while x is 0 on the new line
      if (dot_tick) begin
        if (x_wrap) begin
          raster_x <= '0;
          raster_y <= (raster_y == LAST_Y) ? '0 : raster_y + 9'd1;
        end else begin
          raster_x <= raster_x + 10'd1;
        end
      end
    end
  end

  // two stages, lines up with the colour pipeline
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      sync_q <= 1'b1;
      csync  <= 1'b1;
    end else begin
      sync_q <= !((raster_x < HSYNC_PX) || (raster_y < VSYNC_LINES));
      csync  <= sync_q;
    end
  end

  a_x_range : assert property (
    @(posedge clk_dot4x) disable iff (rst)
    raster_x < LINE_PX
  ) else $error("raster_x out of range");

  a_y_range : assert property (
    @(posedge clk_dot4x) disable iff (rst)
    raster_y < ypos_t'(LINES)
  ) else $error("raster_y out of range");

endmodule : raster_timing

//--- rtl/vic_board.sv
module vic_board
  import vic_pkg::*;
#(
  parameter int LINES  = 312,  // 312 for PAL, 262 for NTSC
  parameter int CYCLES = 63    // 63 for PAL, 65 for NTSC
) (
  input  logic       clk_dot4x,   // 4x dot clock
  input  logic       clk_col4x,   // 4x colour clock
  input  logic       rst,
  output logic       clk_phi,     // cpu phase clock
  output logic       clk_colref,  // colour ref for the encoder
  output logic       csync,
  output logic [1:0] red,
  output logic [1:0] green,
  output logic [1:0] blue,
  inout  tri   [7:0] db,          // shared cpu data bus
  input  logic [5:0] adi,         // register address
  input  logic       ce,          // low = chip selected
  input  logic       rw,          // low = write
  output logic       irq          // active low
);

  rgb_t       rgb;
  logic [7:0] dbo;           // read data from the core
  logic       vic_write_db;  // core owns the data bus

  clk_div4 u_clk_div4 (
    .clk_col4x  (clk_col4x),
    .rst        (rst),
    .clk_colref (clk_colref)
  );

  vicii #(
    .LINES  (LINES),
    .CYCLES (CYCLES)
  ) u_vicii (
    .clk_dot4x    (clk_dot4x),
    .rst          (rst),
    .clk_phi      (clk_phi),
    .csync        (csync),
    .rgb          (rgb),
    .adi          (adi),
    .dbi          (db),
    .dbo          (dbo),
    .vic_write_db (vic_write_db),
    .ce           (ce),
    .rw           (rw),
    .irq          (irq)
  );

  assign red   = rgb[5:4];
  assign green = rgb[3:2];
  assign blue  = rgb[1:0];

  assign db = vic_write_db ? dbo : 8'bz;  // cpu read, else float

endmodule : vic_board

//--- rtl/vic_pkg.sv
package vic_pkg;

  typedef logic [3:0] color_t;  // palette index
  typedef logic [5:0] rgb_t;    // {r[1:0], g[1:0], b[1:0]}
  typedef logic [9:0] xpos_t;   // pixel within a line
  typedef logic [8:0] ypos_t;   // raster line

  typedef enum logic [5:0] {
    REG_CTRL1  = 6'h11,  // bit 7 is raster compare bit 8
    REG_RASTER = 6'h12,  // raster compare low byte
    REG_IRQ    = 6'h19,  // interrupt status
    REG_IRQEN  = 6'h1A,  // interrupt enable
    REG_BORDER = 6'h20,  // border colour
    REG_BG0    = 6'h21   // background colour
  } reg_addr_t;

  localparam xpos_t HSYNC_PX   = 10'd8;   // sync at line start
  localparam xpos_t HBLANK_PX  = 10'd24;  // end of horizontal blank
  localparam xpos_t HBORDER_PX = 10'd32;  // border width both sides

  localparam ypos_t VSYNC_LINES   = 9'd3;   // sync at frame top
  localparam ypos_t VBLANK_LINES  = 9'd8;   // end of vertical blank
  localparam ypos_t VBORDER_LINES = 9'd16;  // border height top and bottom

  // 2 bits per gun, so only a rough match of the usual colours
  localparam rgb_t PALETTE [16] = '{
    6'b00_00_00,  // black
    6'b11_11_11,  // white
    6'b10_00_00,  // red
    6'b01_11_11,  // cyan
    6'b10_00_10,  // purple
    6'b00_10_00,  // green
    6'b00_00_10,  // blue
    6'b11_11_00,  // yellow
    6'b10_01_00,  // orange
    6'b01_01_00,  // brown
    6'b11_01_01,  // light red
    6'b01_01_01,  // dark grey
    6'b10_10_10,  // grey
    6'b01_11_01,  // light green
    6'b01_01_11,  // light blue
    6'b11_11_10   // light grey
  };

endpackage : vic_pkg

//--- rtl/vic_regs.sv
module vic_regs
  import vic_pkg::*;
(
  input  logic       clk_dot4x,
  input  logic       rst,
  input  logic       clk_phi,
  input  logic       phi_end,       // write strobe point
  input  logic [5:0] adi,           // register address
  input  logic [7:0] dbi,           // write data
  output logic [7:0] dbo,           // read data
  output logic       vic_write_db,  // drive the data bus
  input  logic       ce,            // low = selected
  input  logic       rw,            // high = read
  input  ypos_t      raster_y,
  input  logic       line_start,
  output color_t     border_color,
  output color_t     bg_color,
  output logic       irq            // active low
);

  ypos_t raster_cmp;  // raster compare value
  logic  irq_en;      // raster irq enable
  logic  irq_status;  // raster irq latched
  logic  irq_pend;    // enabled and pending
  logic  reg_write;
  logic  irq_clear;
  logic  raster_hit;

  assign reg_write    = phi_end && !ce && !rw;  // end of phi high
  assign vic_write_db = !ce && rw && clk_phi;
  assign irq_pend     = irq_status && irq_en;
  assign irq_clear    = reg_write && (adi == REG_IRQ) && dbi[0];  // write 1 to ack
  assign raster_hit   = line_start && (raster_y == raster_cmp);

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      raster_cmp   <= '0;
      irq_en       <= 1'b0;
      border_color <= '0;
      bg_color     <= '0;
    end else if (reg_write) begin
      case (reg_addr_t'(adi))
        REG_CTRL1:  raster_cmp[8]   <= dbi[7];
        REG_RASTER: raster_cmp[7:0] <= dbi;
        REG_IRQEN:  irq_en          <= dbi[0];
        REG_BORDER: border_color    <= dbi[3:0];
        REG_BG0:    bg_color        <= dbi[3:0];
        default: ;  // status handled below, rest ignored
      endcase
    end
  end

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      irq_status <= 1'b0;
      irq        <= 1'b1;
    end else begin
      if (raster_hit) begin
        irq_status <= 1'b1;  // a new hit beats an ack in the same cycle
      end else if (irq_clear) begin
        irq_status <= 1'b0;
      end
      irq <= !irq_pend;
    end
  end

  // read mux, unused bits read as 1
  always_comb begin
    dbo = 8'hFF;
    case (reg_addr_t'(adi))
      REG_CTRL1:  dbo = {raster_y[8], 7'h7F};
      REG_RASTER: dbo = raster_y[7:0];        // current line, not compare
      REG_IRQ:    dbo = {irq_pend, 6'h3F, irq_status};
      REG_IRQEN:  dbo = {7'h7F, irq_en};
      REG_BORDER: dbo = {4'hF, border_color};
      REG_BG0:    dbo = {4'hF, bg_color};
      default:    dbo = 8'hFF;
    endcase
  end

  // writes happen with rw low so the bus driver is off
  a_no_write_while_driving : assert property (
    @(posedge clk_dot4x) disable iff (rst)
    reg_write |-> !vic_write_db
  ) else $error("register write while driving db");

endmodule : vic_regs

//--- rtl/vicii.sv
module vicii
  import vic_pkg::*;
#(
  parameter int LINES  = 312,
  parameter int CYCLES = 63
) (
  input  logic       clk_dot4x,
  input  logic       rst,
  output logic       clk_phi,
  output logic       csync,
  output rgb_t       rgb,
  input  logic [5:0] adi,
  input  logic [7:0] dbi,
  output logic [7:0] dbo,
  output logic       vic_write_db,
  input  logic       ce,
  input  logic       rw,
  output logic       irq
);

  logic   dot_tick;
  logic   phi_end;
  xpos_t  raster_x;
  ypos_t  raster_y;
  logic   line_start;
  color_t border_color;
  color_t bg_color;

  phi_gen u_phi_gen (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .dot_tick  (dot_tick),
    .clk_phi   (clk_phi),
    .phi_end   (phi_end)
  );

  raster_timing #(
    .LINES  (LINES),
    .CYCLES (CYCLES)
  ) u_raster_timing (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .dot_tick   (dot_tick),
    .raster_x   (raster_x),
    .raster_y   (raster_y),
    .line_start (line_start),
    .csync      (csync)
  );

  vic_regs u_vic_regs (
    .clk_dot4x    (clk_dot4x),
    .rst          (rst),
    .clk_phi      (clk_phi),
    .phi_end      (phi_end),
    .adi          (adi),
    .dbi          (dbi),
    .dbo          (dbo),
    .vic_write_db (vic_write_db),
    .ce           (ce),
    .rw           (rw),
    .raster_y     (raster_y),
    .line_start   (line_start),
    .border_color (border_color),
    .bg_color     (bg_color),
    .irq          (irq)
  );

  color_out #(
    .LINES  (LINES),
    .CYCLES (CYCLES)
  ) u_color_out (
    .clk_dot4x    (clk_dot4x),
    .rst          (rst),
    .raster_x     (raster_x),
    .raster_y     (raster_y),
    .border_color (border_color),
    .bg_color     (bg_color),
    .rgb          (rgb)
  );

endmodule : vicii

//--- tests/tb_vic_board.sv
module tb_vic_board
  import vic_pkg::*;
();

  localparam int LINES    = 48;
  localparam int CYCLES   = 16;
  localparam int LINE_PX  = 8 * CYCLES;
  localparam int FRAME_PX = LINES * LINE_PX;
  localparam int LIMIT    = 3 * FRAME_PX * 4 + 4000;  // three frames plus margin

  logic       clk_dot4x;
  logic       clk_col4x;
  logic       rst;
  logic       clk_phi;
  logic       clk_colref;
  logic       csync;
  logic [1:0] red;
  logic [1:0] green;
  logic [1:0] blue;
  tri   [7:0] db;
  logic [5:0] adi;
  logic       ce;
  logic       rw;
  logic       irq;
  logic       drive_en;     // cpu side owns db
  logic [7:0] drive_data;
  int         seed;
  int         cyc;          // cycles since reset release
  int         errors;
  int         checks;
  int         tests;
  int         test_errors;
  logic       video_req;    // main asks for a frame check
  logic       video_on;
  logic       video_done;
  int         video_cnt;
  color_t     exp_border;
  color_t     exp_bg;

  assign db = drive_en ? drive_data : 8'bz;

  vic_board #(
    .LINES  (LINES),
    .CYCLES (CYCLES)
  ) u_vic_board (
    .clk_dot4x  (clk_dot4x),
    .clk_col4x  (clk_col4x),
    .rst        (rst),
    .clk_phi    (clk_phi),
    .clk_colref (clk_colref),
    .csync      (csync),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .db         (db),
    .adi        (adi),
    .ce         (ce),
    .rw         (rw),
    .irq        (irq)
  );

  initial begin
    clk_dot4x = 1'b0;
    forever #4 clk_dot4x = ~clk_dot4x;
  end

  initial begin
    clk_col4x = 1'b0;
    forever #7 clk_col4x = ~clk_col4x;
  end

  always @(posedge clk_dot4x) begin
    cyc <= rst ? 0 : cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout: run still going after %0d cycles", LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  // {csync, rgb} from the region rules
  function automatic logic [6:0] exp_pixel(input int n, input color_t border, input color_t bg);
    int   x;
    int   y;
    logic sync;
    rgb_t pix;
    x    = n % LINE_PX;
    y    = (n / LINE_PX) % LINES;
    sync = !((x < HSYNC_PX) || (y < VSYNC_LINES));
    if ((x < HBLANK_PX) || (y < VBLANK_LINES)) begin
      pix = '0;
    end else if ((x >= HBORDER_PX) && (x < LINE_PX - HBORDER_PX) &&
                 (y >= VBORDER_LINES) && (y < LINES - VBORDER_LINES)) begin
      pix = PALETTE[bg];
    end else begin
      pix = PALETTE[border];
    end
    return {sync, pix};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("error %s: expected %0h, got %0h", name, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (test_errors == 0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic check_reset_outputs();
    check_eq("reset_irq", 1'b1, irq);
    check_eq("reset_csync", 1'b1, csync);
    check_eq("reset_rgb", 6'd0, {red, green, blue});
    check_eq("reset_db", 8'hzz, db);  // nobody drives the bus
    check_eq("reset_clk_phi", 1'b0, clk_phi);
  endtask

  task automatic cpu_write(input logic [5:0] a, input logic [7:0] d);
    @(negedge clk_dot4x);
    while (!clk_phi) @(negedge clk_dot4x);
    adi        = a;
    ce         = 1'b0;
    rw         = 1'b0;
    drive_data = d;
    drive_en   = 1'b1;
    while (clk_phi) @(negedge clk_dot4x);  // phi_end is behind us once phi drops
    ce       = 1'b1;
    rw       = 1'b1;
    drive_en = 1'b0;
  endtask

  task automatic cpu_read(input logic [5:0] a, output logic [7:0] d);
    @(negedge clk_dot4x);
    while (clk_phi) @(negedge clk_dot4x);
    adi = a;
    ce  = 1'b0;
    rw  = 1'b1;
    while (!clk_phi) @(negedge clk_dot4x);
    repeat (8) @(negedge clk_dot4x);  // middle of phi high
    d  = db;
    ce = 1'b1;
  endtask

  task automatic measure_phi(output int high_len, output int period);
    @(negedge clk_dot4x);
    while (clk_phi) @(negedge clk_dot4x);
    while (!clk_phi) @(negedge clk_dot4x);  // just rose
    high_len = 0;
    while (clk_phi) begin
      @(negedge clk_dot4x);
      high_len++;
    end
    period = high_len;
    while (!clk_phi) begin
      @(negedge clk_dot4x);
      period++;
    end
  endtask

  task automatic measure_colref(output int high_len, output int period);
    @(negedge clk_col4x);
    while (clk_colref) @(negedge clk_col4x);
    while (!clk_colref) @(negedge clk_col4x);
    high_len = 0;
    while (clk_colref) begin
      @(negedge clk_col4x);
      high_len++;
    end
    period = high_len;
    while (!clk_colref) begin
      @(negedge clk_col4x);
      period++;
    end
  endtask

  // pixel n is stable at cycle 4n+2, checked from one frame start to the next
  always @(negedge clk_dot4x) begin : video_compare
    int n;
    if (!rst && (cyc >= 2) && (cyc % 4 == 2)) begin
      n = (cyc - 2) / 4;
      if (video_req && !video_on && !video_done && (n % FRAME_PX == 0)) begin
        video_on  = 1'b1;
        video_cnt = 0;
      end
      if (video_on) begin
        check_eq("video_frame", exp_pixel(n, exp_border, exp_bg), {csync, red, green, blue});
        video_cnt++;
        if (video_cnt == FRAME_PX) begin
          video_on = 1'b0;
          video_done <= 1'b1;
        end
      end
    end
  end

  initial begin : main
    logic [7:0] bd;
    logic [7:0] bg;
    logic [7:0] en;
    logic [7:0] rd;
    int         waited;
    int         hl;
    int         per;
    seed = 32'hc90d;
    rst = 1'b1;
    ce = 1'b1;
    rw = 1'b1;
    adi = '0;
    drive_en = 1'b0;
    drive_data = '0;
    video_req = 1'b0;
    video_on = 1'b0;
    video_done = 1'b0;
    exp_border = '0;
    exp_bg = '0;

    repeat (2) @(negedge clk_dot4x);
    check_reset_outputs();  // during reset
    @(negedge clk_dot4x);
    rst = 1'b0;
    check_reset_outputs();
    @(negedge clk_dot4x);
    check_reset_outputs();  // after the first running edge
    end_test("reset_state");

    measure_phi(hl, per);
    check_eq("clk_phi_high", 16, hl);
    check_eq("clk_phi_period", 32, per);
    measure_colref(hl, per);
    check_eq("clk_colref_high", 2, hl);
    check_eq("clk_colref_period", 4, per);
    end_test("clocks");

    bd = $random(seed);
    bg = $random(seed);
    en = $random(seed);
    cpu_write(REG_BORDER, bd);
    cpu_write(REG_BG0, bg);
    cpu_write(REG_IRQEN, en);
    cpu_read(REG_BORDER, rd);
    check_eq("read_border", {4'hF, bd[3:0]}, rd);
    cpu_read(REG_BG0, rd);
    check_eq("read_bg0", {4'hF, bg[3:0]}, rd);
    cpu_read(REG_IRQEN, rd);
    check_eq("read_irqen", {7'h7F, en[0]}, rd);
    cpu_read(REG_CTRL1, rd);
    check_eq("read_ctrl1", 8'h7F, rd);  // raster bit 8 never set with 48 lines
    cpu_read(6'h3F, rd);
    check_eq("read_unused", 8'hFF, rd);
    end_test("register_access");

    bd = $random(seed);
    bg = $random(seed);
    cpu_write(REG_BORDER, bd);
    cpu_write(REG_BG0, bg);
    exp_border = bd[3:0];
    exp_bg     = bg[3:0];
    video_req <= 1'b1;
    wait (video_done);
    end_test("video_frame");

    cpu_write(REG_RASTER, 8'd30);
    cpu_write(REG_CTRL1, 8'h00);
    cpu_write(REG_IRQ, 8'h01);    // drop anything left from line 0 hits
    cpu_write(REG_IRQEN, 8'h01);
    waited = 0;
    while (irq && (waited < FRAME_PX * 4 + 64)) begin
      @(negedge clk_dot4x);
      waited++;
    end
    checks++;
    assert (!irq) else begin
      $display("irq did not go low within one frame");
      errors++;
      test_errors++;
    end
    cpu_read(REG_RASTER, rd);
    check_eq("irq_raster_line", 8'd30, rd);
    cpu_read(REG_IRQ, rd);
    check_eq("irq_status", 8'hFF, rd);
    cpu_write(REG_IRQ, 8'h01);
    repeat (2) @(negedge clk_dot4x);  // irq output is registered
    check_eq("irq_cleared", 1'b1, irq);
    end_test("raster_irq");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_vic_board

//--- vic_board.f
rtl/vic_pkg.sv
rtl/clk_div4.sv
rtl/phi_gen.sv
rtl/raster_timing.sv
rtl/vic_regs.sv
rtl/color_out.sv
rtl/vicii.sv
rtl/vic_board.sv
tests/tb_vic_board.sv
